// File: saturnInterconnect.f
rtl/saturnPkg.sv
rtl/cpuBusRouter.sv
rtl/peripheralBusRouter.sv
rtl/cdSubBus.sv
rtl/runControl.sv
rtl/saturnInterconnect.sv
verif/saturnInterconnectTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f saturnInterconnect.f --top-module saturnInterconnectTb -o simv \
	&& ./obj_dir/simv > "$LOG" 2>&1

cat "$LOG" 2>/dev/null
[ -s "$LOG" ] || { echo "Simulation did not run"; exit 1; }
grep -q "=== FAIL ===" "$LOG" && { echo "Result: failed"; exit 1; }
grep -q "=== PASS ===" "$LOG" || { echo "Result: no pass line in log"; exit 1; }
echo "Result: passed"

// File: verif/saturnInterconnectTb.sv
module saturnInterconnectTb
	import saturnPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int CPU_COMBOS   = 7;
	localparam int CPU_REPS     = 4;
	localparam int A_COMBOS     = 5;
	localparam int B_COMBOS     = 4;
	localparam int PERIPH_REPS  = 4;
	localparam int CD_ITERS     = 32;
	localparam int CE_ITERS     = 40;
	localparam int RUN_CYCLES   = 20;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 2 + CPU_COMBOS * CPU_REPS
		+ (A_COMBOS + B_COMBOS) * PERIPH_REPS + CD_ITERS + CE_ITERS + RUN_CYCLES;
	// 50 spare cycles on top of the summed test length
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 50) * CLK_PERIOD;

	logic       CLK = 1'b0;

	// Inputs start idle, selects and strobes high
	logic       RST_N = 1'b0;
	memAddrT    cpuAddr = '0;
	word32T     cpuWdata = '0, memDi = '0, scuDo = '0;
	dqmT        cpuDqmN = '1;
	byteT       smpcDo = '0;
	logic       cpuRdN = 1'b1, cs3N = 1'b1, dramCeN = 1'b1, romCeN = 1'b1;
	logic       sramCeN = 1'b1, smpcCeN = 1'b1, scuWaitN = 1'b1, memWaitN = 1'b1;
	logic       aCs0N = 1'b1, aCs1N = 1'b1, aCs2N = 1'b1;
	logic       bCs1N = 1'b1, bCs2N = 1'b1, bCssN = 1'b1;
	logic       cartWaitN = 1'b1, cdWaitN = 1'b1;
	word16T     cartDo = '0, cdDo = '0, vdp1Do = '0, vdp2Do = '0, scspDo = '0;
	subAddrT    subAddr = '0;
	word16T     subDo = '0, hostSdo = '0, cdRamQ = '0;
	logic       cdCe = 1'b0, ramCs1N = 1'b1, subWrlN = 1'b1, subWrhN = 1'b1;
	logic       subRdN = 1'b1, dack0N = 1'b1, dack1N = 1'b1, cdRamRdy = 1'b1;
	logic       smpcCe = 1'b0, vdp1Start = 1'b0, vdp1CmdEnd = 1'b0;
	logic       dbgBreak = 1'b0, dbgRun = 1'b0, dbgPause = 1'b0;

	word32T     cpuRdata, memDo;
	memAddrT    memA;
	dqmT        memDqmN;
	logic       cpuWaitN, memRdN, romCsN, sramCsN, ramlCsN, ramhCsN;
	word16T     aDi, bDi, subDi, cdRamD;
	logic       aWaitN, shceR, shceF, subWaitN, cdRamRd, cdRamCs;
	cdRamAddrT  cdRamA;
	logic [1:0] cdRamWe;
	logic       masterResetN, pause;

	logic [31:0] lcgState = 32'd82;

	saturnInterconnect saturnInterconnect_i (.*);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$fatal(1, "Watchdog expired");
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic randBit();
		logic [31:0] r;
		r = lcgNext();
		return r[16];
	endfunction

	task automatic failNow(input string msg);
		$display("FAIL at %0d ns: %s", $time, msg);
		$display("=== FAIL ===");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic applyReset();
		RST_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		#5;
		assert (!masterResetN && !pause && !shceR && !shceF)
			else failNow("run control or sub-CPU enables active after reset");
	endtask

	task automatic cpuBusTest();
		word32T expData;
		logic   memSel;
		logic   expWait;
		for (int rep = 0; rep < CPU_REPS; rep++) begin
			for (int combo = 0; combo < CPU_COMBOS; combo++) begin
				@(negedge CLK);
				cs3N = (combo != 0 && combo != 5);
				dramCeN = (combo != 1 && combo != 5);
				romCeN = (combo != 2);
				sramCeN = (combo != 3);
				smpcCeN = (combo != 4);
				cpuAddr = memAddrT'(lcgNext());
				cpuWdata = lcgNext();
				cpuDqmN = dqmT'(lcgNext() >> 12);
				cpuRdN = randBit();
				memDi = lcgNext();
				scuDo = lcgNext();
				smpcDo = byteT'(lcgNext() >> 8);
				scuWaitN = randBit();
				memWaitN = randBit();
				#5;
				memSel = (combo <= 3) || (combo == 5);
				if (memSel) begin
					expData = memDi;
				end else if (combo == 4) begin
					expData = {smpcDo, smpcDo, smpcDo, smpcDo};
				end else begin
					expData = scuDo;
				end
				// Memory wait counts only during a memory access
				if (memSel) begin
					expWait = scuWaitN && memWaitN;
				end else begin
					expWait = scuWaitN;
				end
				assert (cpuRdata == expData)
					else failNow($sformatf("cpuRdata %h, expected %h", cpuRdata, expData));
				assert (cpuWaitN == expWait)
					else failNow($sformatf("cpuWaitN %b, expected %b", cpuWaitN, expWait));
				assert (memA == cpuAddr && memDo == cpuWdata && memDqmN == cpuDqmN
					&& memRdN == cpuRdN) else failNow("memory port does not mirror CPU bus");
				assert (romCsN == romCeN && sramCsN == sramCeN && ramlCsN == dramCeN
					&& ramhCsN == cs3N) else failNow("memory chip selects do not follow decode");
			end
		end
	endtask

	task automatic peripheralBusTest();
		word16T expData;
		for (int rep = 0; rep < PERIPH_REPS; rep++) begin
			for (int combo = 0; combo < A_COMBOS; combo++) begin
				@(negedge CLK);
				aCs0N = (combo != 0 && combo != 3);
				aCs1N = (combo != 1);
				aCs2N = (combo != 2 && combo != 3);
				cartDo = word16T'(lcgNext() >> 16);
				cdDo = word16T'(lcgNext() >> 16);
				cartWaitN = randBit();
				cdWaitN = randBit();
				#5;
				// Cartridge wins over CD, open bus floats high
				if (combo == 2) begin
					expData = cdDo;
				end else if (combo == 4) begin
					expData = 16'hFFFF;
				end else begin
					expData = cartDo;
				end
				assert (aDi == expData)
					else failNow($sformatf("aDi %h, expected %h", aDi, expData));
				assert (aWaitN == (cartWaitN & cdWaitN))
					else failNow($sformatf("aWaitN %b, waits %b %b", aWaitN, cartWaitN, cdWaitN));
			end
			for (int combo = 0; combo < B_COMBOS; combo++) begin
				@(negedge CLK);
				bCs1N = (combo != 0);
				bCs2N = (combo != 1);
				bCssN = (combo != 2);
				vdp1Do = word16T'(lcgNext() >> 16);
				vdp2Do = word16T'(lcgNext() >> 16);
				scspDo = word16T'(lcgNext() >> 16);
				#5;
				case (combo)
					0: expData = vdp1Do;
					1: expData = vdp2Do;
					2: expData = scspDo;
					default: expData = 16'h0000;
				endcase
				assert (bDi == expData)
					else failNow($sformatf("bDi %h, expected %h", bDi, expData));
			end
		end
	endtask

	task automatic cdSubBusTest();
		word16T expDi;
		word16T expD;
		for (int i = 0; i < CD_ITERS; i++) begin
			@(negedge CLK);
			subAddr = subAddrT'(lcgNext());
			subDo = word16T'(lcgNext() >> 16);
			hostSdo = word16T'(lcgNext() >> 16);
			cdRamQ = word16T'(lcgNext() >> 16);
			ramCs1N = randBit();
			subWrlN = randBit();
			subWrhN = randBit();
			subRdN = randBit();
			dack0N = randBit();
			dack1N = randBit();
			cdRamRdy = randBit();
			#5;
			expDi = ramCs1N ? hostSdo : cdRamQ;
			// Either DMA channel acknowledged means host data goes to RAM
			if (dack0N == 1'b0 || dack1N == 1'b0) begin
				expD = hostSdo;
			end else begin
				expD = subDo;
			end
			assert (subDi == expDi)
				else failNow($sformatf("subDi %h, expected %h", subDi, expDi));
			assert (cdRamD == expD)
				else failNow($sformatf("cdRamD %h, expected %h", cdRamD, expD));
			assert (cdRamWe == {!subWrhN, !subWrlN} && cdRamRd == !subRdN
				&& cdRamCs == !ramCs1N) else failNow("buffer RAM strobes not inverted");
			assert (cdRamA == subAddr[18:1])
				else failNow($sformatf("cdRamA %h, sub address %h", cdRamA, subAddr));
			assert (subWaitN == cdRamRdy) else failNow("subWaitN does not follow cdRamRdy");
		end
	endtask

	task automatic subEnableTest();
		logic togModel;
		logic seenEnable;
		togModel = 1'b0;
		seenEnable = 1'b0;
		for (int i = 0; i < CE_ITERS; i++) begin
			@(negedge CLK);
			cdCe = randBit();
			#5;
			if (cdCe && !seenEnable) begin
				assert (shceF && !shceR) else failNow("first enabled edge did not give shceF");
				seenEnable = 1'b1;
			end
			assert (shceR == (togModel & cdCe) && shceF == (!togModel & cdCe))
				else failNow($sformatf("shceR %b shceF %b with cdCe %b", shceR, shceF, cdCe));
			@(posedge CLK);
			if (cdCe) begin
				togModel = ~togModel;
			end
		end
		@(negedge CLK);
		cdCe = 1'b0;
	endtask

	task automatic runControlTest();
		repeat (3) begin
			@(posedge CLK);
			#1;
			assert (!masterResetN) else failNow("masterResetN rose without smpcCe");
		end
		@(negedge CLK);
		smpcCe = 1'b1;
		@(posedge CLK);
		#1;
		assert (masterResetN) else failNow("masterResetN did not rise on smpcCe");
		@(negedge CLK);
		smpcCe = 1'b0;
		repeat (3) begin
			@(posedge CLK);
			#1;
			assert (masterResetN) else failNow("masterResetN fell again");
		end
		// Command end before any start must not break
		@(negedge CLK);
		dbgBreak = 1'b1;
		vdp1CmdEnd = 1'b1;
		@(posedge CLK);
		#1;
		assert (!pause) else failNow("vdp1CmdEnd before any start set pause");
		// Break requested at VDP1 start
		@(negedge CLK);
		vdp1CmdEnd = 1'b0;
		dbgBreak = 1'b1;
		vdp1Start = 1'b1;
		#5;
		assert (!pause) else failNow("pause set before the clock edge");
		@(posedge CLK);
		#1;
		assert (pause) else failNow("vdp1Start with dbgBreak did not set pause");
		@(negedge CLK);
		vdp1Start = 1'b0;
		dbgBreak = 1'b0;
		dbgRun = 1'b1;
		@(posedge CLK);
		#1;
		assert (!pause) else failNow("dbgRun did not clear pause");
		// Command end after a start breaks again
		@(negedge CLK);
		dbgRun = 1'b0;
		dbgBreak = 1'b1;
		vdp1CmdEnd = 1'b1;
		@(posedge CLK);
		#1;
		assert (pause) else failNow("vdp1CmdEnd after start did not set pause");
		@(negedge CLK);
		vdp1CmdEnd = 1'b0;
		dbgBreak = 1'b0;
		dbgRun = 1'b1;
		@(posedge CLK);
		#1;
		assert (!pause) else failNow("dbgRun did not clear pause after command end");
		@(negedge CLK);
		dbgRun = 1'b0;
		dbgPause = 1'b1;
		#5;
		assert (pause) else failNow("dbgPause alone did not set pause");
		@(negedge CLK);
		dbgPause = 1'b0;
		#5;
		assert (!pause) else failNow("pause stuck after dbgPause released");
	endtask

	initial begin
		applyReset();
		cpuBusTest();
		peripheralBusTest();
		cdSubBusTest();
		subEnableTest();
		runControlTest();
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: rtl/saturnInterconnect.sv
module saturnInterconnect
	import saturnPkg::*;
(
	input  logic      CLK,
	input  logic      RST_N,

	// Main CPU bus
	input  memAddrT   cpuAddr,
	input  word32T    cpuWdata,
	input  dqmT       cpuDqmN,
	input  logic      cpuRdN,
	input  logic      cs3N,
	input  logic      dramCeN,
	input  logic      romCeN,
	input  logic      sramCeN,
	input  logic      smpcCeN,
	input  word32T    memDi,
	input  byteT      smpcDo,
	input  word32T    scuDo,
	input  logic      scuWaitN,
	input  logic      memWaitN,
	output word32T    cpuRdata,
	output logic      cpuWaitN,
	output memAddrT   memA,
	output word32T    memDo,
	output dqmT       memDqmN,
	output logic      memRdN,
	output logic      romCsN,
	output logic      sramCsN,
	output logic      ramlCsN,
	output logic      ramhCsN,

	// A-bus and B-bus
	input  logic      aCs0N,
	input  logic      aCs1N,
	input  logic      aCs2N,
	input  word16T    cartDo,
	input  word16T    cdDo,
	input  logic      cartWaitN,
	input  logic      cdWaitN,
	input  logic      bCs1N,
	input  logic      bCs2N,
	input  logic      bCssN,
	input  word16T    vdp1Do,
	input  word16T    vdp2Do,
	input  word16T    scspDo,
	output word16T    aDi,
	output logic      aWaitN,
	output word16T    bDi,

	// CD sub-CPU bus
	input  logic      cdCe,
	input  subAddrT   subAddr,
	input  word16T    subDo,
	input  logic      ramCs1N,
	input  logic      subWrlN,
	input  logic      subWrhN,
	input  logic      subRdN,
	input  word16T    hostSdo,
	input  logic      dack0N,
	input  logic      dack1N,
	input  word16T    cdRamQ,
	input  logic      cdRamRdy,
	output logic      shceR,
	output logic      shceF,
	output word16T    subDi,
	output logic      subWaitN,
	output cdRamAddrT cdRamA,
	output word16T    cdRamD,
	output logic [1:0] cdRamWe,
	output logic      cdRamRd,
	output logic      cdRamCs,

	// Run control
	input  logic      smpcCe,
	input  logic      vdp1Start,
	input  logic      vdp1CmdEnd,
	input  logic      dbgBreak,
	input  logic      dbgRun,
	input  logic      dbgPause,
	output logic      masterResetN,
	output logic      pause
);

	cpuBusRouter cpuBusRouter_i (
		.CLK(CLK), .RST_N(RST_N),
		.cpuAddr(cpuAddr), .cpuWdata(cpuWdata), .cpuDqmN(cpuDqmN),
		.cpuRdN(cpuRdN), .cs3N(cs3N),
		.dramCeN(dramCeN), .romCeN(romCeN), .sramCeN(sramCeN), .smpcCeN(smpcCeN),
		.memDi(memDi), .smpcDo(smpcDo), .scuDo(scuDo),
		.scuWaitN(scuWaitN), .memWaitN(memWaitN),
		.cpuRdata(cpuRdata), .cpuWaitN(cpuWaitN),
		.memA(memA), .memDo(memDo), .memDqmN(memDqmN), .memRdN(memRdN),
		.romCsN(romCsN), .sramCsN(sramCsN), .ramlCsN(ramlCsN), .ramhCsN(ramhCsN)
	);

	peripheralBusRouter peripheralBusRouter_i (
		.CLK(CLK), .RST_N(RST_N),
		.aCs0N(aCs0N), .aCs1N(aCs1N), .aCs2N(aCs2N),
		.cartDo(cartDo), .cdDo(cdDo), .cartWaitN(cartWaitN), .cdWaitN(cdWaitN),
		.bCs1N(bCs1N), .bCs2N(bCs2N), .bCssN(bCssN),
		.vdp1Do(vdp1Do), .vdp2Do(vdp2Do), .scspDo(scspDo),
		.aDi(aDi), .aWaitN(aWaitN), .bDi(bDi)
	);

	cdSubBus cdSubBus_i (
		.CLK(CLK), .RST_N(RST_N), .cdCe(cdCe),
		.subAddr(subAddr), .subDo(subDo),
		.ramCs1N(ramCs1N), .subWrlN(subWrlN), .subWrhN(subWrhN), .subRdN(subRdN),
		.hostSdo(hostSdo), .dack0N(dack0N), .dack1N(dack1N),
		.cdRamQ(cdRamQ), .cdRamRdy(cdRamRdy),
		.shceR(shceR), .shceF(shceF), .subDi(subDi), .subWaitN(subWaitN),
		.cdRamA(cdRamA), .cdRamD(cdRamD), .cdRamWe(cdRamWe),
		.cdRamRd(cdRamRd), .cdRamCs(cdRamCs)
	);

	runControl runControl_i (
		.CLK(CLK), .RST_N(RST_N),
		.smpcCe(smpcCe), .vdp1Start(vdp1Start), .vdp1CmdEnd(vdp1CmdEnd),
		.dbgBreak(dbgBreak), .dbgRun(dbgRun), .dbgPause(dbgPause),
		.masterResetN(masterResetN), .pause(pause)
	);

endmodule

// File: rtl/runControl.sv
module runControl (
	input  logic CLK,
	input  logic RST_N,
	input  logic smpcCe,
	input  logic vdp1Start,
	input  logic vdp1CmdEnd,
	input  logic dbgBreak,
	input  logic dbgRun,
	input  logic dbgPause,

	output logic masterResetN,
	output logic pause
);

	logic breakLatch;
	logic started;

	// Held in reset until the SMPC clock first ticks
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			masterResetN <= 1'b0;
		end else if (smpcCe) begin
			masterResetN <= 1'b1;
		end
	end

	// Break on VDP1 start or command end, once a list has started
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			breakLatch <= 1'b0;
			started    <= 1'b0;
		end else if (vdp1Start) begin
			breakLatch <= dbgBreak;
			started    <= 1'b1;
		end else if (vdp1CmdEnd && started) begin
			breakLatch <= dbgBreak;
		end else if (dbgRun) begin
			breakLatch <= 1'b0;
		end
	end

	assign pause = dbgPause | breakLatch;

endmodule

// File: rtl/cdSubBus.sv
module cdSubBus
	import saturnPkg::*;
(
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      cdCe,

	input  subAddrT   subAddr,
	input  word16T    subDo,
	input  logic      ramCs1N,
	input  logic      subWrlN,
	input  logic      subWrhN,
	input  logic      subRdN,

	input  word16T    hostSdo,
	input  logic      dack0N,
	input  logic      dack1N,

	input  word16T    cdRamQ,
	input  logic      cdRamRdy,

	output logic      shceR,
	output logic      shceF,
	output word16T    subDi,
	output logic      subWaitN,

	output cdRamAddrT cdRamA,
	output word16T    cdRamD,
	output logic [1:0] cdRamWe,
	output logic      cdRamRd,
	output logic      cdRamCs
);

	logic shToggle;

	// Halve the CD clock enable into rise/fall phases
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			shToggle <= 1'b0;
		end else if (cdCe) begin
			shToggle <= ~shToggle;
		end
	end

	assign shceR = shToggle & cdCe;
	assign shceF = ~shToggle & cdCe;

	// Buffer RAM on CS1, everything else from the host interface
	assign subDi = !ramCs1N ? cdRamQ : hostSdo;

	assign subWaitN = cdRamRdy;

	// Word address, byte bit dropped
	assign cdRamA = subAddr[18:1];

	// DMA moves host data into the buffer RAM
	assign cdRamD = (!dack0N || !dack1N) ? hostSdo : subDo;

	assign cdRamCs = ~ramCs1N;
	assign cdRamWe = ~{subWrhN, subWrlN};
	assign cdRamRd = ~subRdN;

	shcePhaseExclusive: assert property (
		@(posedge CLK) disable iff (!RST_N)
		!(shceR && shceF)
	) else $error("Sub-CPU rise and fall enables active together");

endmodule

// File: rtl/peripheralBusRouter.sv
module peripheralBusRouter
	import saturnPkg::*;
(
	input  logic   CLK,
	input  logic   RST_N,

	input  logic   aCs0N,
	input  logic   aCs1N,
	input  logic   aCs2N,
	input  word16T cartDo,
	input  word16T cdDo,
	input  logic   cartWaitN,
	input  logic   cdWaitN,

	input  logic   bCs1N,
	input  logic   bCs2N,
	input  logic   bCssN,
	input  word16T vdp1Do,
	input  word16T vdp2Do,
	input  word16T scspDo,

	output word16T aDi,
	output logic   aWaitN,
	output word16T bDi
);

	// A-bus: cartridge owns CS0 and CS1, CD host interface sits on CS2
	always_comb begin
		if (!aCs0N || !aCs1N) begin
			aDi = cartDo;
		end else if (!aCs2N) begin
			aDi = cdDo;
		end else begin
			aDi = A_BUS_OPEN;
		end
	end

	assign aWaitN = cartWaitN & cdWaitN;

	// B-bus priority VDP1, VDP2, SCSP
	always_comb begin
		if (!bCs1N) begin
			bDi = vdp1Do;
		end else if (!bCs2N) begin
			bDi = vdp2Do;
		end else if (!bCssN) begin
			bDi = scspDo;
		end else begin
			bDi = B_BUS_OPEN;
		end
	end

	bSelOneHot: assert property (
		@(posedge CLK) disable iff (!RST_N)
		$onehot0({~bCs1N, ~bCs2N, ~bCssN})
	) else $error("More than one B-bus select active");

endmodule

// File: rtl/cpuBusRouter.sv
module cpuBusRouter
	import saturnPkg::*;
(
	input  logic    CLK,
	input  logic    RST_N,

	input  memAddrT cpuAddr,
	input  word32T  cpuWdata,
	input  dqmT     cpuDqmN,
	input  logic    cpuRdN,
	input  logic    cs3N,

	input  logic    dramCeN,
	input  logic    romCeN,
	input  logic    sramCeN,
	input  logic    smpcCeN,

	input  word32T  memDi,
	input  byteT    smpcDo,
	input  word32T  scuDo,
	input  logic    scuWaitN,
	input  logic    memWaitN,

	output word32T  cpuRdata,
	output logic    cpuWaitN,

	output memAddrT memA,
	output word32T  memDo,
	output dqmT     memDqmN,
	output logic    memRdN,
	output logic    romCsN,
	output logic    sramCsN,
	output logic    ramlCsN,
	output logic    ramhCsN
);

	logic memSel;

	// Any of the four external memories addressed
	assign memSel = !cs3N || !dramCeN || !romCeN || !sramCeN;

	always_comb begin
		if (memSel) begin
			cpuRdata = memDi;
		end else if (!smpcCeN) begin
			cpuRdata = {SMPC_LANES{smpcDo}};
		end else begin
			cpuRdata = scuDo;
		end
	end

	// Memory wait only matters while a memory is selected
	assign cpuWaitN = scuWaitN & (memWaitN | !memSel);

	assign memA    = cpuAddr;
	assign memDo   = cpuWdata;
	assign memDqmN = cpuDqmN;
	assign memRdN  = cpuRdN;

	assign romCsN  = romCeN;
	assign sramCsN = sramCeN;
	assign ramlCsN = dramCeN;
	assign ramhCsN = cs3N;

	// SMPC decode must never overlap a memory window
	smpcMemExclusive: assert property (
		@(posedge CLK) disable iff (!RST_N)
		!(!smpcCeN && memSel)
	) else $error("SMPC select active together with a memory select");

endmodule

// File: rtl/saturnPkg.sv
package saturnPkg;

	// Bus widths
	localparam int CPU_DATA_W   = 32;
	localparam int PERIPH_DATA_W = 16;
	localparam int SMPC_DATA_W  = 8;
	localparam int MEM_ADDR_W   = 25;
	localparam int DQM_W        = 4;
	localparam int CD_RAM_ADDR_W = 18;
	localparam int SUB_ADDR_W   = 22;

	typedef logic [CPU_DATA_W-1:0]    word32T;
	typedef logic [PERIPH_DATA_W-1:0] word16T;
	typedef logic [SMPC_DATA_W-1:0]   byteT;
	typedef logic [MEM_ADDR_W-1:0]    memAddrT;
	typedef logic [DQM_W-1:0]         dqmT;
	typedef logic [CD_RAM_ADDR_W-1:0] cdRamAddrT;
	typedef logic [SUB_ADDR_W-1:0]    subAddrT;

	// Floating A-bus reads back as all ones
	localparam word16T A_BUS_OPEN = 16'hFFFF;

	// B-bus returns zero when nobody answers
	localparam word16T B_BUS_OPEN = 16'h0000;

	// SMPC byte is mirrored on every lane of the 32-bit bus
	localparam int SMPC_LANES = CPU_DATA_W / SMPC_DATA_W;

endpackage
